// ==== source/tlb_pkg.sv ====
package tlb_pkg;

    // coprocessor-0 register and field widths
    localparam int word_width   = 32;
    localparam int vpn2_width   = 19;
    localparam int asid_width   = 8;
    localparam int mask_width   = 12;
    localparam int pfn_width    = 20;
    localparam int cache_width  = 3;
    localparam int offset_width = 12;

    // virtual-address bit choosing lo1 over lo0
    localparam int odd_page_bit = 12;

    // register images, used for TLBWI data and TLBR read-back
    typedef struct packed {
        logic [word_width-1:0] entry_hi;
        logic [word_width-1:0] page_mask;
        logic [word_width-1:0] entry_lo0;
        logic [word_width-1:0] entry_lo1;
    } cp0_regs_t;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [pfn_width-1:0]   pfn;
        logic [cache_width-1:0] c;
        logic                   d;
        logic                   v;
    } tlb_lo_t;

    typedef struct packed {
        logic                  loaded;
        logic [vpn2_width-1:0] vpn2;
        logic [asid_width-1:0] asid;
        logic [mask_width-1:0] mask;
        logic                  g;
        tlb_lo_t               lo0;
        tlb_lo_t               lo1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        exc_none    = 2'd0,
        exc_refill  = 2'd1,
        exc_invalid = 2'd2,
        exc_modify  = 2'd3
    } tlb_exc_e;

    typedef struct packed {
        logic                   hit;
        logic [word_width-1:0]  paddr;
        logic [cache_width-1:0] c;
        logic                   d;
        logic                   v;
        tlb_exc_e               exc;
    } tlb_lookup_t;

    // global entries ignore the current ASID
    function automatic logic asid_ok(
        input tlb_entry_t            entry,
        input logic [asid_width-1:0] asid
    );
        return entry.g || (entry.asid == asid);
    endfunction

endpackage

// ==== source/tlb_entry_store.sv ====
`timescale 1ns/100ps

module tlb_entry_store #(
    parameter int num_entries = 32,
    localparam int index_width = $clog2(num_entries)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wen,
    input  logic [index_width-1:0]                index,
    input  tlb_pkg::cp0_regs_t                    cp0,
    output tlb_pkg::tlb_entry_t [num_entries-1:0] entries,
    output tlb_pkg::cp0_regs_t                    read_regs
);

    tlb_pkg::tlb_entry_t [num_entries-1:0] store;
    tlb_pkg::tlb_entry_t                   new_entry;
    tlb_pkg::tlb_entry_t                   sel_entry;
    logic [num_entries-1:0]                loaded;

    // EntryLo layout: pfn 25:6, c 5:3, d 2, v 1, g 0
    function automatic tlb_pkg::tlb_lo_t decode_lo(
        input logic [tlb_pkg::word_width-1:0] word
    );
        tlb_pkg::tlb_lo_t lo;
        lo.pfn = word[25:6];
        lo.c   = word[5:3];
        lo.d   = word[2];
        lo.v   = word[1];
        return lo;
    endfunction

    function automatic logic [tlb_pkg::word_width-1:0] encode_lo(
        input tlb_pkg::tlb_lo_t lo,
        input logic             g
    );
        return {6'b0, lo.pfn, lo.c, lo.d, lo.v, g};
    endfunction

    always_comb
    begin
        new_entry        = '0;
        new_entry.vpn2   = cp0.entry_hi[31:13];
        new_entry.asid   = cp0.entry_hi[tlb_pkg::asid_width-1:0];
        new_entry.mask   = cp0.page_mask[24:13];
        // only global when both halves say so
        new_entry.g      = cp0.entry_lo0[0] & cp0.entry_lo1[0];
        new_entry.lo0    = decode_lo(cp0.entry_lo0);
        new_entry.lo1    = decode_lo(cp0.entry_lo1);
    end

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            store[index] <= new_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            loaded <= '0;
        end
        else if (wen)
        begin
            loaded[index] <= 1'b1;
        end
    end

    // loaded comes from the reset-cleared vector
    always_comb
    begin
        for (int i = 0; i < num_entries; i++)
        begin
            entries[i]        = store[i];
            entries[i].loaded = loaded[i];
        end
    end

    // TLBR images of the indexed entry
    assign sel_entry = store[index];

    always_comb
    begin
        read_regs.entry_hi  = {sel_entry.vpn2, 5'b0, sel_entry.asid};
        read_regs.page_mask = {7'b0, sel_entry.mask, 13'b0};
        read_regs.entry_lo0 = encode_lo(sel_entry.lo0, sel_entry.g);
        read_regs.entry_lo1 = encode_lo(sel_entry.lo1, sel_entry.g);
    end

    a_index_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wen |-> !$isunknown(index)
    ) else $error("write strobe with unknown index");

endmodule

// ==== source/tlb_lookup_port.sv ====
`timescale 1ns/100ps

module tlb_lookup_port #(
    parameter int num_entries = 32
) (
    input  logic [tlb_pkg::word_width-1:0]        vaddr,
    input  logic [tlb_pkg::asid_width-1:0]        asid,
    input  tlb_pkg::tlb_entry_t [num_entries-1:0] entries,
    output tlb_pkg::tlb_lookup_t                  result
);

    logic [num_entries-1:0] hit_vec;
    logic                   hit;
    logic                   odd;
    tlb_pkg::tlb_lo_t       picked;

    assign odd = vaddr[tlb_pkg::odd_page_bit];

    // masked VPN2 compare, bits 24:13 are don't-care where mask is set
    for (genvar i = 0; i < num_entries; i++)
    begin : g_match
        logic upper_eq;
        logic lower_eq;

        assign upper_eq = vaddr[31:25] == entries[i].vpn2[18:12];
        assign lower_eq = ((vaddr[24:13] ^ entries[i].vpn2[11:0])
                          & ~entries[i].mask) == '0;

        assign hit_vec[i] = entries[i].loaded && upper_eq && lower_eq
                            && tlb_pkg::asid_ok(entries[i], asid);
    end

    assign hit = |hit_vec;

    // at most one hit, so OR-ing the picked halves is a mux
    always_comb
    begin
        picked = '0;
        for (int i = 0; i < num_entries; i++)
        begin
            if (hit_vec[i])
            begin
                picked = picked | (odd ? entries[i].lo1 : entries[i].lo0);
            end
        end
    end

    always_comb
    begin
        result     = '0;
        result.hit = hit;
        if (hit)
        begin
            result.paddr = {picked.pfn, vaddr[tlb_pkg::offset_width-1:0]};
            result.c     = picked.c;
            result.d     = picked.d;
            result.v     = picked.v;
        end

        // refill > invalid > modify
        if (!hit)
        begin
            result.exc = tlb_pkg::exc_refill;
        end
        else if (!picked.v)
        begin
            result.exc = tlb_pkg::exc_invalid;
        end
        else if (!picked.d)
        begin
            result.exc = tlb_pkg::exc_modify;
        end
        else
        begin
            result.exc = tlb_pkg::exc_none;
        end
    end

    // uniqueness is kept by software through the write port
    a_hit_onehot: assert final ($onehot0(hit_vec))
        else $error("lookup hit in more than one entry");

endmodule

// ==== source/tlb_probe.sv ====
`timescale 1ns/100ps

module tlb_probe #(
    parameter int num_entries = 32,
    localparam int index_width = $clog2(num_entries)
) (
    input  logic [tlb_pkg::word_width-1:0]        entry_hi,
    input  tlb_pkg::tlb_entry_t [num_entries-1:0] entries,
    output logic                                  probe_hit,
    output logic [index_width-1:0]                probe_index
);

    logic [num_entries-1:0] hit_vec;

    // exact VPN2, page mask not applied
    for (genvar i = 0; i < num_entries; i++)
    begin : g_probe
        assign hit_vec[i] = entries[i].loaded
                            && (entries[i].vpn2 == entry_hi[31:13])
                            && tlb_pkg::asid_ok(entries[i],
                                   entry_hi[tlb_pkg::asid_width-1:0]);
    end

    assign probe_hit = |hit_vec;

    // zero when nothing hits
    always_comb
    begin
        probe_index = '0;
        for (int i = 0; i < num_entries; i++)
        begin
            if (hit_vec[i])
            begin
                probe_index = probe_index | index_width'(i);
            end
        end
    end

    a_probe_unique: assert final ($onehot0(hit_vec))
        else $error("probe matched more than one entry");

endmodule

// ==== source/tlb_top.sv ====
`timescale 1ns/100ps

module tlb_top #(
    parameter int num_entries = 32,
    localparam int index_width = $clog2(num_entries)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wen,
    input  logic [index_width-1:0]         index,
    input  tlb_pkg::cp0_regs_t             cp0,
    input  logic [tlb_pkg::word_width-1:0] inst_vaddr,
    input  logic [tlb_pkg::word_width-1:0] data_vaddr,
    output tlb_pkg::tlb_lookup_t           inst_result,
    output tlb_pkg::tlb_lookup_t           data_result,
    output tlb_pkg::cp0_regs_t             read_regs,
    output logic                           probe_hit,
    output logic [index_width-1:0]         probe_index
);

    tlb_pkg::tlb_entry_t [num_entries-1:0] entries;
    logic [tlb_pkg::asid_width-1:0]        cur_asid;

    // current ASID from EntryHi
    assign cur_asid = cp0.entry_hi[tlb_pkg::asid_width-1:0];

    tlb_entry_store #(
        .num_entries (num_entries)
    ) u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .wen       (wen),
        .index     (index),
        .cp0       (cp0),
        .entries   (entries),
        .read_regs (read_regs)
    );

    tlb_lookup_port #(
        .num_entries (num_entries)
    ) u_inst_port (
        .vaddr   (inst_vaddr),
        .asid    (cur_asid),
        .entries (entries),
        .result  (inst_result)
    );

    tlb_lookup_port #(
        .num_entries (num_entries)
    ) u_data_port (
        .vaddr   (data_vaddr),
        .asid    (cur_asid),
        .entries (entries),
        .result  (data_result)
    );

    tlb_probe #(
        .num_entries (num_entries)
    ) u_probe (
        .entry_hi    (cp0.entry_hi),
        .entries     (entries),
        .probe_hit   (probe_hit),
        .probe_index (probe_index)
    );

endmodule

// ==== verification/tlb_checker.sv ====
`timescale 1ns/100ps

module tlb_checker #(
    parameter int index_width = 5
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             check_en,
    input  logic [127:0]           test_name,
    input  tlb_pkg::tlb_lookup_t   exp_inst,
    input  tlb_pkg::tlb_lookup_t   exp_data,
    input  logic                   exp_probe_hit,
    input  logic [index_width-1:0] exp_probe_index,
    input  tlb_pkg::cp0_regs_t     exp_read,
    input  tlb_pkg::tlb_lookup_t   inst_result,
    input  tlb_pkg::tlb_lookup_t   data_result,
    input  logic                   probe_hit,
    input  logic [index_width-1:0] probe_index,
    input  tlb_pkg::cp0_regs_t     read_regs,
    input  logic                   report,
    output int                     error_count
);

    int check_count;

    initial
    begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare(
        input string        what,
        input logic [127:0] expected,
        input logic [127:0] actual
    );
        check_count++;
        if ($isunknown(actual))
        begin
            error_count++;
            $display("test %s: %s has unknown bits (%0h)", test_name, what, actual);
        end
        else if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] test %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // check_en bits: 0 inst, 1 data, 2 probe, 3 read-back
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (check_en[0])
                compare("inst_result", exp_inst, inst_result);
            if (check_en[1])
                compare("data_result", exp_data, data_result);
            if (check_en[2])
                compare("probe", {exp_probe_hit, exp_probe_index}, {probe_hit, probe_index});
            if (check_en[3])
                compare("read_regs", exp_read, read_regs);
        end
    end

    always @(posedge report)
    begin
        $display("checks: %0d  errors: %0d", check_count, error_count);
    end

endmodule

// ==== verification/tlb_tb.sv ====
`timescale 1ns/100ps

module tlb_tb;

    localparam int num_entries = 32;
    localparam int index_width = $clog2(num_entries);
    localparam int max_rows    = 32;

    logic                   clk;
    logic                   rst_n;
    logic                   wen;
    logic [index_width-1:0] index;
    tlb_pkg::cp0_regs_t     cp0;
    logic [31:0]            inst_vaddr;
    logic [31:0]            data_vaddr;
    tlb_pkg::tlb_lookup_t   inst_result;
    tlb_pkg::tlb_lookup_t   data_result;
    tlb_pkg::cp0_regs_t     read_regs;
    logic                   probe_hit;
    logic [index_width-1:0] probe_index;

    // expectations of the row on the inputs
    logic [3:0]             check_en;
    logic [127:0]           test_name;
    tlb_pkg::tlb_lookup_t   exp_inst;
    tlb_pkg::tlb_lookup_t   exp_data;
    logic                   exp_probe_hit;
    logic [index_width-1:0] exp_probe_index;
    tlb_pkg::cp0_regs_t     exp_read;
    logic                   report;
    int                     error_count;

    // stimulus table
    logic [127:0]           row_name      [max_rows];
    logic                   row_wen       [max_rows];
    logic [index_width-1:0] row_index     [max_rows];
    tlb_pkg::cp0_regs_t     row_cp0       [max_rows];
    logic [31:0]            row_ivaddr    [max_rows];
    logic [31:0]            row_dvaddr    [max_rows];
    logic [3:0]             row_chk       [max_rows];
    tlb_pkg::tlb_lookup_t   row_exp_inst  [max_rows];
    tlb_pkg::tlb_lookup_t   row_exp_data  [max_rows];
    logic                   row_exp_phit  [max_rows];
    logic [index_width-1:0] row_exp_pidx  [max_rows];
    tlb_pkg::cp0_regs_t     row_exp_read  [max_rows];
    int                     num_rows;
    logic                   table_ready;
    integer                 seed;
    logic [11:0]            off_i;
    logic [11:0]            off_d;

    tlb_top #(
        .num_entries (num_entries)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (wen),
        .index       (index),
        .cp0         (cp0),
        .inst_vaddr  (inst_vaddr),
        .data_vaddr  (data_vaddr),
        .inst_result (inst_result),
        .data_result (data_result),
        .read_regs   (read_regs),
        .probe_hit   (probe_hit),
        .probe_index (probe_index)
    );

    tlb_checker #(
        .index_width (index_width)
    ) u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .check_en        (check_en),
        .test_name       (test_name),
        .exp_inst        (exp_inst),
        .exp_data        (exp_data),
        .exp_probe_hit   (exp_probe_hit),
        .exp_probe_index (exp_probe_index),
        .exp_read        (exp_read),
        .inst_result     (inst_result),
        .data_result     (data_result),
        .probe_hit       (probe_hit),
        .probe_index     (probe_index),
        .read_regs       (read_regs),
        .report          (report),
        .error_count     (error_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] hi_word(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    function automatic logic [31:0] mask_word(input logic [11:0] mask);
        return {7'b0, mask, 13'b0};
    endfunction

    // EntryLo: pfn 25:6, c 5:3, d, v, g
    function automatic logic [31:0] lo_word(
        input logic [19:0] pfn,
        input logic [2:0]  c,
        input logic        d,
        input logic        v,
        input logic        g
    );
        return {6'b0, pfn, c, d, v, g};
    endfunction

    function automatic logic [31:0] vaddr_of(
        input logic [18:0] vpn2,
        input logic        odd,
        input logic [11:0] offset
    );
        return {vpn2, odd, offset};
    endfunction

    function automatic tlb_pkg::cp0_regs_t regs_of(
        input logic [31:0] hi,
        input logic [31:0] mask,
        input logic [31:0] lo0,
        input logic [31:0] lo1
    );
        tlb_pkg::cp0_regs_t r;
        r.entry_hi  = hi;
        r.page_mask = mask;
        r.entry_lo0 = lo0;
        r.entry_lo1 = lo1;
        return r;
    endfunction

    function automatic tlb_pkg::cp0_regs_t cur_regs(input logic [18:0] vpn2, input logic [7:0] asid);
        return regs_of(hi_word(vpn2, asid), 32'h0, 32'h0, 32'h0);
    endfunction

    function automatic tlb_pkg::tlb_lookup_t hit_of(
        input logic [19:0]       pfn,
        input logic [11:0]       offset,
        input logic [2:0]        c,
        input logic              d,
        input logic              v,
        input tlb_pkg::tlb_exc_e exc
    );
        tlb_pkg::tlb_lookup_t r;
        r.hit   = 1'b1;
        r.paddr = {pfn, offset};
        r.c     = c;
        r.d     = d;
        r.v     = v;
        r.exc   = exc;
        return r;
    endfunction

    function automatic tlb_pkg::tlb_lookup_t miss_of();
        tlb_pkg::tlb_lookup_t r;
        r     = '0;
        r.exc = tlb_pkg::exc_refill;
        return r;
    endfunction

    task automatic new_offsets();
        integer r;
        r = $random(seed);
        off_i = r[11:0];
        r = $random(seed);
        off_d = r[11:0];
    endtask

    task automatic add_row(
        input logic [127:0]           name,
        input logic                   w,
        input logic [index_width-1:0] idx,
        input tlb_pkg::cp0_regs_t     regs,
        input logic [31:0]            iva,
        input logic [31:0]            dva
    );
        row_name[num_rows]     = name;
        row_wen[num_rows]      = w;
        row_index[num_rows]    = idx;
        row_cp0[num_rows]      = regs;
        row_ivaddr[num_rows]   = iva;
        row_dvaddr[num_rows]   = dva;
        row_chk[num_rows]      = 4'b0;
        row_exp_inst[num_rows] = '0;
        row_exp_data[num_rows] = '0;
        row_exp_phit[num_rows] = 1'b0;
        row_exp_pidx[num_rows] = '0;
        row_exp_read[num_rows] = '0;
        num_rows++;
    endtask

    task automatic expect_lookup(input tlb_pkg::tlb_lookup_t ir, input tlb_pkg::tlb_lookup_t dr);
        row_exp_inst[num_rows-1]     = ir;
        row_exp_data[num_rows-1]     = dr;
        row_chk[num_rows-1][1:0]     = 2'b11;
    endtask

    task automatic expect_probe(input logic hit, input logic [index_width-1:0] idx);
        row_exp_phit[num_rows-1] = hit;
        row_exp_pidx[num_rows-1] = idx;
        row_chk[num_rows-1][2]   = 1'b1;
    endtask

    task automatic expect_read(input tlb_pkg::cp0_regs_t regs);
        row_exp_read[num_rows-1] = regs;
        row_chk[num_rows-1][3]   = 1'b1;
    endtask

    task automatic build_table();
        tlb_pkg::cp0_regs_t   w3;
        tlb_pkg::cp0_regs_t   w7;
        tlb_pkg::cp0_regs_t   w12;
        tlb_pkg::cp0_regs_t   w20;
        tlb_pkg::cp0_regs_t   w20b;
        tlb_pkg::tlb_lookup_t miss;
        miss = miss_of();
        num_rows = 0;
        // junk outside the fields of entry 3 must not read back
        w3 = regs_of(hi_word(19'h00010, 8'h05) | 32'h0000_1f00, 32'hfe00_1fff,
                     lo_word(20'h11111, 3'd3, 1'b1, 1'b1, 1'b0) | 32'hfc00_0000,
                     lo_word(20'h22222, 3'd2, 1'b1, 1'b1, 1'b0));
        // only one global bit set, so not global
        w7 = regs_of(hi_word(19'h00020, 8'h05), 32'h0,
                     lo_word(20'h33333, 3'd3, 1'b0, 1'b1, 1'b1),
                     lo_word(20'h44444, 3'd0, 1'b0, 1'b0, 1'b0));
        w12 = regs_of(hi_word(19'h00030, 8'h09), 32'h0,
                      lo_word(20'h55555, 3'd1, 1'b1, 1'b1, 1'b1),
                      lo_word(20'h66666, 3'd4, 1'b1, 1'b1, 1'b1));
        w20 = regs_of(hi_word(19'h40040, 8'h05), mask_word(12'h003),
                      lo_word(20'h77777, 3'd3, 1'b1, 1'b1, 1'b0),
                      lo_word(20'h88888, 3'd3, 1'b1, 1'b1, 1'b0));
        w20b = regs_of(hi_word(19'h40050, 8'h05), 32'h0,
                       lo_word(20'h99999, 3'd2, 1'b1, 1'b1, 1'b0),
                       lo_word(20'haaaaa, 3'd5, 1'b1, 1'b1, 1'b0));

        new_offsets();
        add_row("reset_idle", 1'b0, 5'd0, cur_regs(19'h00010, 8'h05),
                vaddr_of(19'h00010, 1'b0, off_i), vaddr_of(19'h00030, 1'b1, off_d));
        expect_lookup(miss, miss);
        expect_probe(1'b0, 5'd0);

        add_row("wr_3", 1'b1, 5'd3, w3, 32'h0, 32'h0);
        add_row("wr_7", 1'b1, 5'd7, w7, 32'h0, 32'h0);
        add_row("wr_12", 1'b1, 5'd12, w12, 32'h0, 32'h0);
        add_row("wr_20", 1'b1, 5'd20, w20, 32'h0, 32'h0);

        add_row("rd_3", 1'b0, 5'd3, '0, 32'h0, 32'h0);
        expect_read(regs_of(hi_word(19'h00010, 8'h05), 32'h0,
                            lo_word(20'h11111, 3'd3, 1'b1, 1'b1, 1'b0),
                            lo_word(20'h22222, 3'd2, 1'b1, 1'b1, 1'b0)));
        add_row("rd_7", 1'b0, 5'd7, '0, 32'h0, 32'h0);
        expect_read(regs_of(hi_word(19'h00020, 8'h05), 32'h0,
                            lo_word(20'h33333, 3'd3, 1'b0, 1'b1, 1'b0),
                            lo_word(20'h44444, 3'd0, 1'b0, 1'b0, 1'b0)));
        add_row("rd_12", 1'b0, 5'd12, '0, 32'h0, 32'h0);
        expect_read(w12);
        add_row("rd_20", 1'b0, 5'd20, '0, 32'h0, 32'h0);
        expect_read(w20);

        new_offsets();
        add_row("xlate_even_both", 1'b0, 5'd0, cur_regs(19'h00010, 8'h05),
                vaddr_of(19'h00010, 1'b0, off_i), vaddr_of(19'h40040, 1'b1, off_d));
        expect_lookup(hit_of(20'h11111, off_i, 3'd3, 1'b1, 1'b1, tlb_pkg::exc_none),
                      hit_of(20'h88888, off_d, 3'd3, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b1, 5'd3);

        new_offsets();
        add_row("xlate_odd_glob", 1'b0, 5'd0, cur_regs(19'h00010, 8'h05),
                vaddr_of(19'h00010, 1'b1, off_i), vaddr_of(19'h00030, 1'b0, off_d));
        expect_lookup(hit_of(20'h22222, off_i, 3'd2, 1'b1, 1'b1, tlb_pkg::exc_none),
                      hit_of(20'h55555, off_d, 3'd1, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b1, 5'd3);

        new_offsets();
        add_row("exc_refill_inv", 1'b0, 5'd0, cur_regs(19'h00020, 8'h05),
                vaddr_of(19'h00050, 1'b0, off_i), vaddr_of(19'h00020, 1'b1, off_d));
        expect_lookup(miss,
                      hit_of(20'h44444, off_d, 3'd0, 1'b0, 1'b0, tlb_pkg::exc_invalid));
        expect_probe(1'b1, 5'd7);

        new_offsets();
        add_row("exc_modify_none", 1'b0, 5'd0, cur_regs(19'h00030, 8'h05),
                vaddr_of(19'h00020, 1'b0, off_i), vaddr_of(19'h00030, 1'b1, off_d));
        expect_lookup(hit_of(20'h33333, off_i, 3'd3, 1'b0, 1'b1, tlb_pkg::exc_modify),
                      hit_of(20'h66666, off_d, 3'd4, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b1, 5'd12);

        // ASID 6 owns nothing, only the global entry survives
        new_offsets();
        add_row("asid_other", 1'b0, 5'd0, cur_regs(19'h00010, 8'h06),
                vaddr_of(19'h00010, 1'b0, off_i), vaddr_of(19'h00030, 1'b0, off_d));
        expect_lookup(miss,
                      hit_of(20'h55555, off_d, 3'd1, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b0, 5'd0);

        new_offsets();
        add_row("mask_hit", 1'b0, 5'd0, cur_regs(19'h40040, 8'h05),
                vaddr_of(19'h40043, 1'b0, off_i), vaddr_of(19'h40042, 1'b1, off_d));
        expect_lookup(hit_of(20'h77777, off_i, 3'd3, 1'b1, 1'b1, tlb_pkg::exc_none),
                      hit_of(20'h88888, off_d, 3'd3, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b1, 5'd20);

        // probe ignores the mask
        new_offsets();
        add_row("mask_miss", 1'b0, 5'd0, cur_regs(19'h40041, 8'h05),
                vaddr_of(19'h40044, 1'b0, off_i), vaddr_of(19'h00040, 1'b0, off_d));
        expect_lookup(miss, miss);
        expect_probe(1'b0, 5'd0);

        // new entry not yet there at this edge
        add_row("probe_rewrite", 1'b1, 5'd20, w20b, 32'h0, 32'h0);
        expect_probe(1'b0, 5'd0);

        new_offsets();
        add_row("after_rewrite", 1'b0, 5'd0, cur_regs(19'h40040, 8'h05),
                vaddr_of(19'h40040, 1'b0, off_i), vaddr_of(19'h40050, 1'b1, off_d));
        expect_lookup(miss,
                      hit_of(20'haaaaa, off_d, 3'd5, 1'b1, 1'b1, tlb_pkg::exc_none));
        expect_probe(1'b0, 5'd0);

        add_row("probe_new", 1'b0, 5'd20, cur_regs(19'h40050, 8'h05), 32'h0, 32'h0);
        expect_probe(1'b1, 5'd20);
        expect_read(w20b);
    endtask

    task automatic apply_row(input int r);
        wen             = row_wen[r];
        index           = row_index[r];
        cp0             = row_cp0[r];
        inst_vaddr      = row_ivaddr[r];
        data_vaddr      = row_dvaddr[r];
        test_name       = row_name[r];
        check_en        = row_chk[r];
        exp_inst        = row_exp_inst[r];
        exp_data        = row_exp_data[r];
        exp_probe_hit   = row_exp_phit[r];
        exp_probe_index = row_exp_pidx[r];
        exp_read        = row_exp_read[r];
    endtask

    initial
    begin
        rst_n           = 1'b0;
        wen             = 1'b0;
        index           = '0;
        cp0             = '0;
        inst_vaddr      = 32'h0;
        data_vaddr      = 32'h0;
        check_en        = 4'b0;
        test_name       = '0;
        exp_inst        = '0;
        exp_data        = '0;
        exp_probe_hit   = 1'b0;
        exp_probe_index = '0;
        exp_read        = '0;
        report          = 1'b0;
        table_ready     = 1'b0;
        seed            = 32'h9254;
        build_table();
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < num_rows; r++)
        begin
            @(negedge clk);
            apply_row(r);
        end

        // last row is sampled on the edge before this one
        @(negedge clk);
        check_en = 4'b0;
        wen      = 1'b0;
        report   = 1'b1;
        #1;
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (table_ready === 1'b1);
        #((5 + num_rows + 20) * 100);
        $display("timeout: the test sequence did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tlb.f ====
source/tlb_pkg.sv
source/tlb_entry_store.sv
source/tlb_lookup_port.sv
source/tlb_probe.sv
source/tlb_top.sv
verification/tlb_checker.sv
verification/tlb_tb.sv
